//--- src/image_pkg.sv
package image_pkg;

    // Every sample in the stream is one byte of grayscale intensity.
    localparam int PixelWidth = 8;

    // The weighted 3x3 sum peaks at 255 * 16 + 8 = 4088, so twelve bits
    // are enough to hold it without overflow.
    localparam int PixelSumWidth = 12;

    typedef bit [PixelWidth-1:0] pixel_t;

    // Wide enough for the sum of all products plus the rounding term.
    typedef bit [PixelSumWidth-1:0] pixel_sum_t;

endpackage : image_pkg

//--- src/kernel_pkg.sv
package kernel_pkg;

    // Height and width of the square neighborhood.
    localparam int KernelSize = 3;

    localparam int KernelTaps = KernelSize * KernelSize;

    // Binomial weights in row-major order. They add up to 16.
    localparam int KernelWeights [KernelTaps] = '{
        1, 2, 1,
        2, 4, 2,
        1, 2, 1
    };

    // Half of the weight total, so that the shift rounds to nearest.
    localparam int RoundOffset = 8;

    localparam int NormShift = 4;  // Divides by the weight total.

endpackage : kernel_pkg

//--- src/vertical_sliding_window.sv
`timescale 1ns/1ps

module vertical_sliding_window
    import image_pkg::*;
#(
    parameter int InHeight = 480,
    parameter int InWidth = 640,
    parameter int WindowHeight = 3
) (
    input  bit clock_i,
    input  bit reset_i,

    input  bit     slave_valid_i,
    output bit     slave_ready_o,
    input  pixel_t slave_data_i,

    output bit                        master_valid_o,
    input  bit                        master_ready_i,
    output pixel_t [WindowHeight-1:0] master_data_o
);

    localparam int LineCount = WindowHeight - 1;  // Rows kept in line memories.
    localparam int SelWidth = (LineCount > 1) ? $clog2(LineCount) : 1;

    typedef bit [$clog2(InHeight)-1:0] row_t;
    typedef bit [$clog2(InWidth)-1:0] column_t;
    typedef bit [SelWidth-1:0] line_sel_t;

    bit        accept;
    row_t      row;
    row_t      next_row;
    column_t   column;
    column_t   next_column;
    line_sel_t line_sel;
    line_sel_t line_sel_q;

    pixel_t line_mem [LineCount][InWidth];
    pixel_t read_ahead [LineCount];
    pixel_t line_q [LineCount];
    pixel_t pass_q;
    bit     valid_q;

    // The whole pipeline stalls together, so ready simply follows downstream.
    assign slave_ready_o = reset_i && master_ready_i;
    assign accept = slave_valid_i && slave_ready_o;

    always_comb begin
        next_row = row;
        next_column = column + column_t'(1);
        if (column == column_t'(InWidth - 1)) begin
            next_column = '0;
            if (row == row_t'(InHeight - 1)) begin
                next_row = '0;  // Frames follow back to back.
            end else begin
                next_row = row + row_t'(1);
            end
        end
    end

    always_ff @(posedge clock_i) begin
        if (!reset_i) begin
            row <= '0;
            column <= '0;
        end else if (accept) begin
            row <= next_row;
            column <= next_column;
        end
    end

    // Rows rotate through the line memories.
    assign line_sel = line_sel_t'(row % row_t'(LineCount));

    always_ff @(posedge clock_i) begin
        if (accept) begin
            line_mem[line_sel][column] <= slave_data_i;
        end
    end

    // The memories are read one column ahead, so the older rows for the
    // next pixel are already fetched when that pixel arrives.
    always_ff @(posedge clock_i) begin
        if (accept) begin
            for (int i = 0; i < LineCount; i++) begin
                read_ahead[i] <= line_mem[i][next_column];
            end
        end
    end

    always_ff @(posedge clock_i) begin
        if (master_ready_i) begin
            line_q <= read_ahead;
            line_sel_q <= line_sel;
            pass_q <= slave_data_i;
        end
    end

    // The memory being overwritten holds the oldest row, so counting up from
    // its index gives the rows from oldest to newest.
    always_comb begin
        for (int i = 0; i < LineCount; i++) begin
            master_data_o[i] = line_q[(int'(line_sel_q) + i) % LineCount];
        end
        master_data_o[WindowHeight-1] = pass_q;  // Current row.
    end

    always_ff @(posedge clock_i) begin
        if (!reset_i) begin
            valid_q <= 1'b0;
        end else if (master_ready_i) begin
            valid_q <= slave_valid_i && (row >= row_t'(LineCount));
        end
    end

    assign master_valid_o = reset_i && valid_q;

endmodule : vertical_sliding_window

//--- src/horizontal_sliding_window.sv
`timescale 1ns/1ps

module horizontal_sliding_window
    import image_pkg::*;
    import kernel_pkg::*;
#(
    parameter int InWidth = 640
) (
    input  bit clock_i,
    input  bit reset_i,

    input  bit                      slave_valid_i,
    output bit                      slave_ready_o,
    input  pixel_t [KernelSize-1:0] slave_data_i,

    output bit                      master_valid_o,
    input  bit                      master_ready_i,
    output pixel_t [KernelTaps-1:0] master_data_o
);

    typedef bit [$clog2(InWidth)-1:0] column_t;

    bit      accept;
    column_t column;
    bit      valid_q;

    // Entry 0 is the previous column, the last entry the oldest one.
    pixel_t [KernelSize-1:0] history [KernelSize-1];
    pixel_t [KernelTaps-1:0] window;

    assign slave_ready_o = reset_i && master_ready_i;
    assign accept = slave_valid_i && slave_ready_o;

    always_ff @(posedge clock_i) begin
        if (!reset_i) begin
            column <= '0;
        end else if (accept) begin
            if (column == column_t'(InWidth - 1)) begin
                column <= '0;
            end else begin
                column <= column + column_t'(1);
            end
        end
    end

    always_ff @(posedge clock_i) begin
        if (accept) begin
            history[0] <= slave_data_i;
            for (int k = 1; k < KernelSize - 1; k++) begin
                history[k] <= history[k-1];
            end
        end
    end

    // Row-major neighborhood with the incoming column on the right.
    always_comb begin
        for (int r = 0; r < KernelSize; r++) begin
            for (int k = 0; k < KernelSize - 1; k++) begin
                window[r*KernelSize+k] = history[KernelSize-2-k][r];
            end
            window[r*KernelSize+KernelSize-1] = slave_data_i[r];
        end
    end

    always_ff @(posedge clock_i) begin
        if (accept) begin
            master_data_o <= window;
        end
    end

    // Early columns would mix pixels from the end of the previous row.
    always_ff @(posedge clock_i) begin
        if (!reset_i) begin
            valid_q <= 1'b0;
        end else if (master_ready_i) begin
            valid_q <= slave_valid_i && (column >= column_t'(KernelSize - 1));
        end
    end

    assign master_valid_o = reset_i && valid_q;

endmodule : horizontal_sliding_window

//--- src/gaussian_kernel.sv
`timescale 1ns/1ps

module gaussian_kernel
    import image_pkg::*;
    import kernel_pkg::*;
(
    input  bit clock_i,
    input  bit reset_i,

    input  bit                      slave_valid_i,
    output bit                      slave_ready_o,
    input  pixel_t [KernelTaps-1:0] slave_data_i,

    output bit     master_valid_o,
    input  bit     master_ready_i,
    output pixel_t master_data_o
);

    bit         accept;
    pixel_sum_t weighted_sum;
    pixel_sum_t normalized;
    bit         valid_q;

    assign slave_ready_o = reset_i && master_ready_i;
    assign accept = slave_valid_i && slave_ready_o;

    // The rounding term seeds the sum.
    always_comb begin
        weighted_sum = pixel_sum_t'(RoundOffset);
        for (int i = 0; i < KernelTaps; i++) begin
            weighted_sum = weighted_sum
                + pixel_sum_t'(KernelWeights[i]) * pixel_sum_t'(slave_data_i[i]);
        end
    end

    assign normalized = weighted_sum >> NormShift;  // At most 255 after the shift.

    always_ff @(posedge clock_i) begin
        if (accept) begin
            master_data_o <= pixel_t'(normalized);
        end
    end

    always_ff @(posedge clock_i) begin
        if (!reset_i) begin
            valid_q <= 1'b0;
        end else if (master_ready_i) begin
            valid_q <= slave_valid_i;
        end
    end

    assign master_valid_o = reset_i && valid_q;

endmodule : gaussian_kernel

//--- src/blur_filter_top.sv
`timescale 1ns/1ps

module blur_filter_top
    import image_pkg::*;
    import kernel_pkg::*;
#(
    parameter int InHeight = 480,
    parameter int InWidth = 640
) (
    input  bit clock_i,
    input  bit reset_i,

    input  bit     pixel_valid_i,
    output bit     pixel_ready_o,
    input  pixel_t pixel_i,

    output bit     blur_valid_o,
    input  bit     blur_ready_i,
    output pixel_t blur_o
);

    // Column of vertically adjacent pixels, oldest row first.
    bit                      column_valid;
    bit                      column_ready;
    pixel_t [KernelSize-1:0] column_data;

    // Full neighborhood in row-major order.
    bit                      window_valid;
    bit                      window_ready;
    pixel_t [KernelTaps-1:0] window_data;

    vertical_sliding_window #(
        .InHeight(InHeight),
        .InWidth(InWidth),
        .WindowHeight(KernelSize)
    ) i_vertical_sliding_window (
        .clock_i(clock_i),
        .reset_i(reset_i),
        .slave_valid_i(pixel_valid_i),
        .slave_ready_o(pixel_ready_o),
        .slave_data_i(pixel_i),
        .master_valid_o(column_valid),
        .master_ready_i(column_ready),
        .master_data_o(column_data)
    );

    horizontal_sliding_window #(
        .InWidth(InWidth)
    ) i_horizontal_sliding_window (
        .clock_i(clock_i),
        .reset_i(reset_i),
        .slave_valid_i(column_valid),
        .slave_ready_o(column_ready),
        .slave_data_i(column_data),
        .master_valid_o(window_valid),
        .master_ready_i(window_ready),
        .master_data_o(window_data)
    );

    gaussian_kernel i_gaussian_kernel (
        .clock_i(clock_i),
        .reset_i(reset_i),
        .slave_valid_i(window_valid),
        .slave_ready_o(window_ready),
        .slave_data_i(window_data),
        .master_valid_o(blur_valid_o),
        .master_ready_i(blur_ready_i),
        .master_data_o(blur_o)
    );

endmodule : blur_filter_top

//--- verif/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
    parameter int Period = 20,
    parameter int ResetCycles = 5
) (
    output bit clock_o,
    output bit reset_o
);

    initial begin
        clock_o = 1'b0;
        forever begin
            #(Period / 2) clock_o = ~clock_o;
        end
    end

    // Active-low reset, lifted just after a rising edge like the other inputs.
    initial begin
        reset_o = 1'b0;
        repeat (ResetCycles) @(posedge clock_o);
        #1 reset_o = 1'b1;
    end

endmodule : clock_gen

//--- verif/blur_filter_tb.sv
`timescale 1ns/1ps

module blur_filter_tb
    import image_pkg::*;
();

    localparam int InHeight = 6;
    localparam int InWidth = 10;
    localparam int NumFrames = 6;
    localparam int FramePixels = InHeight * InWidth;
    localparam int OutPerFrame = (InHeight - 2) * (InWidth - 2);
    localparam int TotalOutputs = NumFrames * OutPerFrame;
    localparam int CycleLimit = NumFrames * FramePixels * 4 + 100;  // Room for gaps and stalls.
    localparam int unsigned RandomSeed = 32'hbd232111;

    bit     clock;
    bit     reset_n;
    bit     pixel_valid_i;
    bit     pixel_ready_o;
    pixel_t pixel_i;
    bit     blur_valid_o;
    bit     blur_ready_i;
    pixel_t blur_o;

    pixel_t frames [NumFrames][FramePixels];
    int     expected_q [$];
    int     received_count;
    int     cycle_count;
    bit     stalled;
    pixel_t stalled_value;

    clock_gen #(
        .Period(20),
        .ResetCycles(5)
    ) i_clock_gen (
        .clock_o(clock),
        .reset_o(reset_n)
    );

    blur_filter_top #(
        .InHeight(InHeight),
        .InWidth(InWidth)
    ) i_blur_filter_top (
        .clock_i(clock),
        .reset_i(reset_n),
        .pixel_valid_i(pixel_valid_i),
        .pixel_ready_o(pixel_ready_o),
        .pixel_i(pixel_i),
        .blur_valid_o(blur_valid_o),
        .blur_ready_i(blur_ready_i),
        .blur_o(blur_o)
    );

    task automatic check_value(input int actual, input int expected, input string what);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s: got %0d, expected %0d", $time, what, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "Value mismatch.");
        end
    endtask

    // Gaussian 1 2 1 weights on the 3x3 block whose lower right corner is (r, c).
    function automatic int blur_at(input int f, input int r, input int c);
        int sum;
        int weight;
        sum = 8;  // Rounds the division by 16 to nearest.
        for (int dr = 0; dr < 3; dr++) begin
            for (int dc = 0; dc < 3; dc++) begin
                weight = ((dr == 1) ? 2 : 1) * ((dc == 1) ? 2 : 1);
                sum += weight * int'(frames[f][(r - 2 + dr) * InWidth + (c - 2 + dc)]);
            end
        end
        return sum >> 4;
    endfunction

    function automatic void queue_expected(input int f);
        for (int r = 2; r < InHeight; r++) begin
            for (int c = 2; c < InWidth; c++) begin
                expected_q.push_back(blur_at(f, r, c));
            end
        end
    endfunction

    // Offers one frame, holding a pixel until it is taken.
    task automatic send_frame(input int f, input int gap_pct, input int stall_pct);
        int idx;
        bit hold;
        idx = 0;
        hold = 1'b0;
        while (idx < FramePixels) begin
            // Every output of the earlier frames has drained before row 2 of this one.
            if (idx == 2 * InWidth) begin
                check_value(received_count, f * OutPerFrame,
                    $sformatf("outputs before row 2 of frame %0d", f));
            end
            if (!hold) begin
                pixel_valid_i = ($urandom_range(99) >= gap_pct);
            end
            pixel_i = frames[f][idx];
            blur_ready_i = ($urandom_range(99) >= stall_pct);
            @(posedge clock);
            hold = pixel_valid_i && !pixel_ready_o;
            if (pixel_valid_i && pixel_ready_o) begin
                idx++;
            end
            #1;
        end
    endtask

    initial begin
        pixel_valid_i = 1'b0;
        pixel_i = '0;
        blur_ready_i = 1'b1;
        void'($urandom(RandomSeed));

        for (int f = 0; f < 4; f++) begin
            for (int i = 0; i < FramePixels; i++) begin
                frames[f][i] = pixel_t'($urandom);
            end
        end
        for (int i = 0; i < FramePixels; i++) begin
            frames[4][i] = 8'd255;  // Upper bound of the sum.
            frames[5][i] = ((i % InWidth) < InWidth / 2) ? 8'd0 : 8'd255;
        end
        for (int f = 0; f < NumFrames; f++) begin
            queue_expected(f);
        end

        wait (reset_n == 1'b1);
        repeat (3) begin
            @(posedge clock);
            check_value(int'(blur_valid_o), 0, "blur_valid_o right after reset");
            #1;
        end

        send_frame(0, 0, 0);
        send_frame(1, 0, 0);   // Back to back with the first one.
        send_frame(2, 30, 0);
        send_frame(3, 0, 30);
        send_frame(4, 0, 0);
        send_frame(5, 0, 0);

        pixel_valid_i = 1'b0;
        blur_ready_i = 1'b1;
        wait (received_count == TotalOutputs);
        repeat (10) @(posedge clock);  // Any extra output shows up here.

        $display("SIMULATION PASSED");
        $finish;
    end

    always @(posedge clock) begin
        if (!reset_n) begin
            check_value(int'(blur_valid_o), 0, "blur_valid_o during reset");
            check_value(int'(pixel_ready_o), 0, "pixel_ready_o during reset");
        end else begin
            check_value(int'(pixel_ready_o), int'(blur_ready_i), "pixel_ready_o vs blur_ready_i");
            if (stalled) begin
                check_value(int'(blur_valid_o), 1, "blur_valid_o held under back-pressure");
                check_value(int'(blur_o), int'(stalled_value), "blur_o held under back-pressure");
            end
            stalled = blur_valid_o && !blur_ready_i;
            stalled_value = blur_o;
            if (blur_valid_o && blur_ready_i) begin
                if (expected_q.size() == 0) begin
                    $display("The DUT produced an output at %0t ns after all frames were done.",
                        $time);
                    $display("SIMULATION FAILED");
                    $fatal(1, "Extra output.");
                end else begin
                    check_value(int'(blur_o), expected_q.pop_front(),
                        $sformatf("blurred pixel %0d", received_count));
                    received_count++;
                end
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > CycleLimit) begin
            $display("Timeout: the output stream did not finish within %0d cycles.", CycleLimit);
            $display("SIMULATION FAILED");
            $fatal(1, "Timeout.");
        end
    end

endmodule : blur_filter_tb

//--- project.f
src/image_pkg.sv
src/kernel_pkg.sv
src/vertical_sliding_window.sv
src/horizontal_sliding_window.sv
src/gaussian_kernel.sv
src/blur_filter_top.sv
verif/clock_gen.sv
verif/blur_filter_tb.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it once.
# The result is taken from the simulator output, which is also shown.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module blur_filter_tb \
    -f project.f -o blur_filter_sim \
    && ./obj_dir/blur_filter_sim | tee /dev/stderr | grep -q "^SIMULATION PASSED$" \
    && echo "run.sh: test run succeeded" \
    || { echo "run.sh: test run did not succeed"; exit 1; }
